//--- logic/prf_defs.svh
// PRF configuration constants
// Widths and port counts for the register file and its users
`ifndef PRF_DEFS_SVH
`define PRF_DEFS_SVH

// Register value width
`define NCPU_DW 64

// Physical register address width, 64 registers
`define NCPU_PRF_AW 6

// Log2 of issue lanes
`define NCPU_P_ISSUE_WIDTH 1

// Log2 of commit lanes
`define NCPU_P_COMMIT_WIDTH 1

// Two source operands per issue lane
`define NCPU_NUM_RD ((1 << `NCPU_P_ISSUE_WIDTH) * 2)

// One write lane per commit lane
`define NCPU_NUM_WR (1 << `NCPU_P_COMMIT_WIDTH)

`endif

//--- logic/prf_types_pkg.sv
// PRF data and address types
// Single-entry and flattened per-lane vectors
`default_nettype none
`include "prf_defs.svh"

package prf_types_pkg;

   // One physical register
   typedef logic [`NCPU_PRF_AW-1:0] preg_addr_t;
   typedef logic [`NCPU_DW-1:0]     preg_data_t;

   // All read ports, lane 0 in the low bits
   typedef logic [`NCPU_NUM_RD*`NCPU_PRF_AW-1:0] rd_addr_vec_t;
   typedef logic [`NCPU_NUM_RD*`NCPU_DW-1:0]     rd_data_vec_t;

   // All write lanes, same packing
   typedef logic [`NCPU_NUM_WR*`NCPU_PRF_AW-1:0] wb_addr_vec_t;
   typedef logic [`NCPU_NUM_WR*`NCPU_DW-1:0]     wb_data_vec_t;

endpackage

`default_nettype wire

//--- logic/prf_lane_pkg.sv
// PRF lane mask types
// One bit per read port or per write lane
`default_nettype none
`include "prf_defs.svh"

package prf_lane_pkg;

   // Read enables, one per operand port
   typedef logic [`NCPU_NUM_RD-1:0] rd_mask_t;

   // Write enables and WB ready levels
   typedef logic [`NCPU_NUM_WR-1:0] wb_mask_t;

   // Lane 0 is the one shared with LSU/EPU
   localparam int unsigned SHARED_LANE = 0;

   // Number of lanes that carry no back-pressure
   localparam int unsigned FREE_LANES = `NCPU_NUM_WR - 1;

endpackage

`default_nettype wire

//--- logic/mrf_nwnr.sv
// Multi-port register storage, NUM_WRITE write lanes and NUM_READ read ports
// Reads are registered with one cycle of latency and hold when not enabled
`default_nettype none
`include "prf_defs.svh"

module mrf_nwnr
#(
   parameter int unsigned NUM_READ  = `NCPU_NUM_RD,
   parameter int unsigned NUM_WRITE = `NCPU_NUM_WR
)
(
   input  wire                                            clk,
   input  wire                                            arst_n,

   // Read side
   input  wire  [NUM_READ-1:0]                            re,
   input  wire  prf_types_pkg::preg_addr_t [NUM_READ-1:0] raddr,
   output prf_types_pkg::preg_data_t [NUM_READ-1:0]       rdata,

   // Write side
   input  wire  [NUM_WRITE-1:0]                            we,
   input  wire  prf_types_pkg::preg_addr_t [NUM_WRITE-1:0] waddr,
   input  wire  prf_types_pkg::preg_data_t [NUM_WRITE-1:0] wdata
);
   import prf_types_pkg::*;

   // Entry count follows the address width
   localparam int unsigned NUM_REGS = 1 << `NCPU_PRF_AW;

   // Register array
   preg_data_t regs [NUM_REGS];

   // Per-port output registers
   preg_data_t rd_q [NUM_READ];

   // All write lanes update on the same edge
   // Lanes never share an address, so order does not matter
   always_ff @(posedge clk)
   begin
      for (int w = 0; w < NUM_WRITE; w++)
      begin
         if (we[w])
         begin
            regs[waddr[w]] <= wdata[w];
         end
      end
   end

   // Read ports
   for (genvar k = 0; k < NUM_READ; k++)
   begin : g_rd
      // Samples the array before this edge's writes land
      // Holds the last value while re is low
      always_ff @(posedge clk or negedge arst_n)
      begin
         if (!arst_n)
         begin
            rd_q[k] <= '0;
         end
         else if (re[k])
         begin
            rd_q[k] <= regs[raddr[k]];
         end
      end

      assign rdata[k] = rd_q[k];
   end

   // Checks across write lanes
   for (genvar a = 0; a < NUM_WRITE; a++)
   begin : g_wcol_a
      for (genvar b = a + 1; b < NUM_WRITE; b++)
      begin : g_wcol_b
         // No two lanes may hit one register in a cycle
         a_no_wr_collision: assert property (
            @(posedge clk) disable iff (!arst_n)
            !(we[a] && we[b] && (waddr[a] == waddr[b])))
            else $error("write lanes %0d and %0d collide on preg %0d", a, b, waddr[a]);
      end
   end

endmodule

`default_nettype wire

//--- logic/prf_wb_arbiter.sv
// Lane-0 write arbiter between WB and LSU/EPU
// LSU/EPU has fixed priority, WB lane 0 sees ready drop while it writes
`default_nettype none
`include "prf_defs.svh"

module prf_wb_arbiter
(
   // From WB
   input  wire  prf_lane_pkg::wb_mask_t      prf_we,
   input  wire  prf_types_pkg::wb_addr_vec_t prf_waddr,
   input  wire  prf_types_pkg::wb_data_vec_t prf_wdata,

   // From LSU/EPU
   input  wire                               prf_we_lsu_epu,
   input  wire  prf_types_pkg::preg_addr_t   prf_waddr_lsu_epu,
   input  wire  prf_types_pkg::preg_data_t   prf_wdata_lsu_epu,

   // To array
   output prf_lane_pkg::wb_mask_t            arr_we,
   output prf_types_pkg::wb_addr_vec_t       arr_waddr,
   output prf_types_pkg::wb_data_vec_t       arr_wdata,

   // To WB
   output prf_lane_pkg::wb_mask_t            wb_ready
);
   import prf_types_pkg::*;
   import prf_lane_pkg::*;

   localparam int unsigned AW = `NCPU_PRF_AW;
   localparam int unsigned DW = `NCPU_DW;
   localparam int unsigned L0 = SHARED_LANE;

   // WB lane 0 fields
   preg_addr_t wb0_waddr;
   preg_data_t wb0_wdata;

   assign wb0_waddr = prf_waddr[L0*AW +: AW];
   assign wb0_wdata = prf_wdata[L0*DW +: DW];

   // Lane 0, LSU/EPU wins and WB is told to hold
   assign wb_ready[L0]             = ~prf_we_lsu_epu;
   assign arr_we[L0]               = prf_we_lsu_epu | prf_we[L0];
   assign arr_waddr[L0*AW +: AW]   = prf_we_lsu_epu ? prf_waddr_lsu_epu : wb0_waddr;
   assign arr_wdata[L0*DW +: DW]   = prf_we_lsu_epu ? prf_wdata_lsu_epu : wb0_wdata;

   // Higher lanes pass through, never stalled
   for (genvar i = 1; i <= FREE_LANES; i++)
   begin : g_lane
      assign wb_ready[i]          = 1'b1;
      assign arr_we[i]            = prf_we[i];
      assign arr_waddr[i*AW +: AW] = prf_waddr[i*AW +: AW];
      assign arr_wdata[i*DW +: DW] = prf_wdata[i*DW +: DW];
   end

   // LSU/EPU write owns lane 0 and WB lane 0 is held off
   always_comb
   begin
      a_lsu_owns_lane0: assert final (!prf_we_lsu_epu ||
         (!wb_ready[L0] && arr_we[L0] && (arr_waddr[L0*AW +: AW] == prf_waddr_lsu_epu)))
         else $error("LSU/EPU write lost lane 0");
   end

endmodule

`default_nettype wire

//--- logic/prf.sv
// Physical register file top
// Operand reads for RO, WB and LSU/EPU writes merged through the lane-0 arbiter
`default_nettype none
`include "prf_defs.svh"

module prf
(
   input  wire                                clk,
   input  wire                                arst_n,

   // From RO
   input  wire  prf_lane_pkg::rd_mask_t       prf_re,
   input  wire  prf_types_pkg::rd_addr_vec_t  prf_raddr,
   // To RO
   output prf_types_pkg::rd_data_vec_t        prf_rdata,

   // From WB
   input  wire  prf_lane_pkg::wb_mask_t       prf_we,
   input  wire  prf_types_pkg::wb_addr_vec_t  prf_waddr,
   input  wire  prf_types_pkg::wb_data_vec_t  prf_wdata,

   // From LSU/EPU
   input  wire                                prf_we_lsu_epu,
   input  wire  prf_types_pkg::preg_addr_t    prf_waddr_lsu_epu,
   input  wire  prf_types_pkg::preg_data_t    prf_wdata_lsu_epu,

   // To WB
   output prf_lane_pkg::wb_mask_t             wb_ready
);
   import prf_types_pkg::*;
   import prf_lane_pkg::*;

   // Merged write lanes into the array
   wb_mask_t     arr_we;
   wb_addr_vec_t arr_waddr;
   wb_data_vec_t arr_wdata;

   // LSU/EPU priority on lane 0
   prf_wb_arbiter u_wb_arb
   (
      .prf_we            (prf_we),
      .prf_waddr         (prf_waddr),
      .prf_wdata         (prf_wdata),
      .prf_we_lsu_epu    (prf_we_lsu_epu),
      .prf_waddr_lsu_epu (prf_waddr_lsu_epu),
      .prf_wdata_lsu_epu (prf_wdata_lsu_epu),
      .arr_we            (arr_we),
      .arr_waddr         (arr_waddr),
      .arr_wdata         (arr_wdata),
      .wb_ready          (wb_ready)
   );

   // Two operand ports per issue lane, one write lane per commit lane
   mrf_nwnr
   #(
      .NUM_READ  (`NCPU_NUM_RD),
      .NUM_WRITE (`NCPU_NUM_WR)
   )
   u_prf_array
   (
      .clk    (clk),
      .arst_n (arst_n),
      .re     (prf_re),
      .raddr  (prf_raddr),
      .rdata  (prf_rdata),
      .we     (arr_we),
      .waddr  (arr_waddr),
      .wdata  (arr_wdata)
   );

endmodule

`default_nettype wire

//--- tests/tb_prf.sv
// PRF testbench
// Reference model checks every read lane and wb_ready on each cycle
`default_nettype none
`include "prf_defs.svh"

module tb_prf;
   import prf_types_pkg::*;
   import prf_lane_pkg::*;

   localparam int AW  = `NCPU_PRF_AW;
   localparam int DW  = `NCPU_DW;
   localparam int NRD = `NCPU_NUM_RD;
   localparam int NWR = `NCPU_NUM_WR;

   // Cycle budget of each test
   localparam int LEN_T1 = 4;
   localparam int LEN_T2 = 100;
   localparam int LEN_T3 = 6;
   localparam int LEN_T4 = 5;
   localparam int LEN_T5 = 8;
   localparam int LEN_T6 = 302;
   localparam int CYCLE_LIMIT = 2 + LEN_T1 + LEN_T2 + LEN_T3 + LEN_T4 + LEN_T5 + LEN_T6 + 50;

   logic         clk;
   logic         arst_n;
   rd_mask_t     prf_re;
   rd_addr_vec_t prf_raddr;
   rd_data_vec_t prf_rdata;
   wb_mask_t     prf_we;
   wb_addr_vec_t prf_waddr;
   wb_data_vec_t prf_wdata;
   logic         prf_we_lsu_epu;
   preg_addr_t   prf_waddr_lsu_epu;
   preg_data_t   prf_wdata_lsu_epu;
   wb_mask_t     wb_ready;

   // Reference register contents and expected read lanes
   preg_data_t ref_mem [preg_addr_t];
   preg_data_t exp_rd [NRD];

   int     errors;
   int     checks;
   int     tests;
   int     cycles;
   int     test_err_base;
   integer seed;

   prf uut
   (
      .clk               (clk),
      .arst_n            (arst_n),
      .prf_re            (prf_re),
      .prf_raddr         (prf_raddr),
      .prf_rdata         (prf_rdata),
      .prf_we            (prf_we),
      .prf_waddr         (prf_waddr),
      .prf_wdata         (prf_wdata),
      .prf_we_lsu_epu    (prf_we_lsu_epu),
      .prf_waddr_lsu_epu (prf_waddr_lsu_epu),
      .prf_wdata_lsu_epu (prf_wdata_lsu_epu),
      .wb_ready          (wb_ready)
   );

   initial
   begin
      clk = 1'b0;
   end

   always #20 clk = ~clk;

   // Expected register value, unknown if never written
   function automatic preg_data_t ref_read(input preg_addr_t addr);
      if (ref_mem.exists(addr))
         return ref_mem[addr];
      return 'x;
   endfunction

   // Only lane 0 is stalled, and only by an LSU/EPU write
   function automatic wb_mask_t expected_ready(input logic lsu_we);
      wb_mask_t r;
      r = '1;
      r[0] = ~lsu_we;
      return r;
   endfunction

   task automatic check_data(input int lane, input preg_data_t got, input preg_data_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Fail prf_rdata[%0d]: got %h, expected %h", lane, got, exp);
      end
   endtask

   task automatic check_ready(input wb_mask_t got, input wb_mask_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Fail wb_ready: got %h, expected %h", got, exp);
      end
   endtask

   // Model update on each edge, reads see contents before the writes
   always @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int k = 0; k < NRD; k++)
            exp_rd[k] = '0;
      end
      else
      begin
         for (int k = 0; k < NRD; k++)
            if (prf_re[k])
               exp_rd[k] = ref_read(prf_raddr[k*AW +: AW]);
         // LSU/EPU takes lane 0, a WB lane-0 write is dropped then
         if (prf_we_lsu_epu)
            ref_mem[prf_waddr_lsu_epu] = prf_wdata_lsu_epu;
         else if (prf_we[0])
            ref_mem[prf_waddr[0 +: AW]] = prf_wdata[0 +: DW];
         for (int i = 1; i < NWR; i++)
            if (prf_we[i])
               ref_mem[prf_waddr[i*AW +: AW]] = prf_wdata[i*DW +: DW];
      end
   end

   // Compare mid-cycle, outputs settled since the rising edge
   always @(negedge clk)
   begin
      if (arst_n)
      begin
         for (int k = 0; k < NRD; k++)
            check_data(k, prf_rdata[k*DW +: DW], exp_rd[k]);
         check_ready(wb_ready, expected_ready(prf_we_lsu_epu));
      end
   end

   // Run limit
   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("Timeout after %0d cycles, the tests did not finish", cycles);
         $display("sim failed");
         $finish;
      end
   end

   // Step to just after the next rising edge
   task automatic next_cycle;
      @(posedge clk);
      #2;
   endtask

   task automatic clear_inputs;
      prf_re = '0;
      prf_we = '0;
      prf_we_lsu_epu = 1'b0;
   endtask

   // Idle long enough for the last read to be compared
   task automatic settle;
      clear_inputs();
      next_cycle();
      next_cycle();
   endtask

   task automatic drive_read(input int k, input preg_addr_t addr);
      prf_re[k] = 1'b1;
      prf_raddr[k*AW +: AW] = addr;
   endtask

   task automatic drive_write(input int i, input preg_addr_t addr, input preg_data_t data);
      prf_we[i] = 1'b1;
      prf_waddr[i*AW +: AW] = addr;
      prf_wdata[i*DW +: DW] = data;
   endtask

   task automatic drive_lsu(input preg_addr_t addr, input preg_data_t data);
      prf_we_lsu_epu = 1'b1;
      prf_waddr_lsu_epu = addr;
      prf_wdata_lsu_epu = data;
   endtask

   task automatic finish_test(input string name);
      tests++;
      $display("test %0d %s: done, %0d errors", tests, name, errors - test_err_base);
      test_err_base = errors;
   endtask

   function automatic preg_data_t rand_data;
      return preg_data_t'({$random(seed), $random(seed)});
   endfunction

   initial
   begin
      preg_addr_t a0;
      preg_addr_t a1;
      preg_addr_t al;
      errors = 0;
      checks = 0;
      tests = 0;
      cycles = 0;
      test_err_base = 0;
      seed = 32;
      arst_n = 1'b0;
      prf_raddr = '0;
      prf_waddr = '0;
      prf_wdata = '0;
      prf_waddr_lsu_epu = '0;
      prf_wdata_lsu_epu = '0;
      clear_inputs();
      repeat (2) @(posedge clk);
      #2 arst_n = 1'b1;

      // Zero read lanes and full ready after reset
      repeat (3) next_cycle();
      finish_test("reset state");

      // Fill every register, even ones on lane 0 and odd ones on lane 1
      for (int r = 0; r < 64; r += 2)
      begin
         clear_inputs();
         drive_write(0, preg_addr_t'(r), rand_data());
         drive_write(1, preg_addr_t'(r + 1), rand_data());
         next_cycle();
      end
      for (int r = 0; r < 64; r++)
      begin
         clear_inputs();
         for (int k = 0; k < NRD; k++)
            drive_read(k, preg_addr_t'(r));
         next_cycle();
      end
      settle();
      finish_test("fill and read all");

      // LSU/EPU and WB lane 0 meet, WB keeps its write until ready
      clear_inputs();
      drive_lsu(6'd10, rand_data());
      drive_write(0, 6'd11, rand_data());
      next_cycle();
      prf_we_lsu_epu = 1'b0;
      drive_read(0, 6'd11);
      drive_read(1, 6'd10);
      next_cycle();
      clear_inputs();
      drive_read(2, 6'd11);
      settle();
      finish_test("lsu priority");

      // Same-cycle read sees the old value, the next read the new one
      clear_inputs();
      drive_write(1, 6'd5, rand_data());
      drive_read(0, 6'd5);
      next_cycle();
      clear_inputs();
      drive_read(1, 6'd5);
      settle();
      finish_test("read during write");

      // Lane 2 holds while its register keeps changing
      clear_inputs();
      drive_read(2, 6'd20);
      next_cycle();
      repeat (4)
      begin
         clear_inputs();
         drive_write(1, 6'd20, rand_data());
         drive_write(0, 6'd21, rand_data());
         next_cycle();
      end
      settle();
      finish_test("read hold");

      // Random traffic, write lanes kept on distinct registers
      for (int c = 0; c < 300; c++)
      begin
         clear_inputs();
         for (int k = 0; k < NRD; k++)
            if ($random(seed) & 1)
               drive_read(k, preg_addr_t'($random(seed)));
         a0 = preg_addr_t'($random(seed));
         a1 = preg_addr_t'($random(seed));
         if (a1 == a0)
            a1 = a0 + 1'b1;
         al = preg_addr_t'($random(seed));
         if (al == a1)
            al = a1 + 1'b1;
         if ($random(seed) & 1)
            drive_write(0, a0, rand_data());
         if ($random(seed) & 1)
            drive_write(1, a1, rand_data());
         if (($random(seed) & 3) == 0)
            drive_lsu(al, rand_data());
         next_cycle();
      end
      settle();
      finish_test("random mix");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- ncpu_prf.f
+incdir+logic
logic/prf_types_pkg.sv
logic/prf_lane_pkg.sv
logic/mrf_nwnr.sv
logic/prf_wb_arbiter.sv
logic/prf.sv
tests/tb_prf.sv

//--- Bender.yml
package:
  name: ncpu_prf

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/prf_types_pkg.sv
      - logic/prf_lane_pkg.sv
      - logic/mrf_nwnr.sv
      - logic/prf_wb_arbiter.sv
      - logic/prf.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/tb_prf.sv
